/* include/drv_params.svh */
`ifndef DRV_PARAMS_SVH
`define DRV_PARAMS_SVH

// ######################################################################
// Driver column geometry
// ######################################################################

// One SIN line per driver in the column
`define DRV_CHANNELS 30

// SCLK bits in one grayscale or configuration word
`define DRV_WORD_BITS 48

// Grayscale words that make up one frame
`define DRV_WORDS_PER_FRAME 16

// ######################################################################
// Latch commands, counted as trailing SCLK edges with LAT high
// ######################################################################

`define DRV_FCWRTEN_LEN 15
`define DRV_WRTFC_LEN 5
`define DRV_WRTGS_LEN 1
`define DRV_LATGS_LEN 3

// Clocks with SCLK stopped after the last bit of every frame
`define DRV_BLANK_CYCLES 80

// Clocks spent on each SOUT multiplexer position during LOD
`define DRV_LOD_DWELL 8

`endif

/* source/drv_pkg.sv */
`include "drv_params.svh"

package drv_pkg;

   // One bit per driver in the column
   // Carries SIN words, framebuffer slices and the open-LED flags
   typedef logic [`DRV_CHANNELS-1:0] sin_word_t;

   // Function control word as written with WRTFC
   typedef logic [`DRV_WORD_BITS-1:0] cfg_word_t;

   // Bit position inside the word being shifted
   typedef logic [5:0] bit_idx_t;

   // Select of the external SOUT multiplexer
   typedef logic [4:0] mux_sel_t;

   // Top level mode of the controller
   typedef enum logic [1:0] {
      STALL,
      CONFIG,
      STREAM,
      LOD
   } drv_state_t;

   // Command that the current word ends with
   typedef enum logic [2:0] {
      NO_LAT,
      FCWRTEN,
      WRTFC,
      WRTGS,
      LATGS
   } lat_cmd_t;

   // What goes onto the SIN lines during a shift cycle
   typedef enum logic [1:0] {
      SIN_ZERO,
      SIN_CFG,
      SIN_FB
   } sin_src_t;

endpackage

/* source/driver_main_controller.sv */
`include "drv_params.svh"

module driver_main_controller (
   input  logic               clk_33,
   input  logic               nrst,
   input  logic               start,
   input  logic               framebuffer_sync,
   input  logic               lod_req,
   input  logic               lod_done,
   output drv_pkg::drv_state_t state,
   output logic               shift_en,
   output drv_pkg::bit_idx_t  bit_idx,
   output drv_pkg::lat_cmd_t  lat_cmd,
   output drv_pkg::sin_src_t  sin_src,
   output logic               lod_start,
   output logic               stream_ready,
   output logic               driver_sclk,
   output logic               driver_gclk
);
   import drv_pkg::*;

   localparam bit_idx_t FC_LAST = bit_idx_t'(`DRV_FCWRTEN_LEN - 1);
   localparam bit_idx_t WORD_LAST = bit_idx_t'(`DRV_WORD_BITS - 1);
   localparam int WORD_W = $clog2(`DRV_WORDS_PER_FRAME);
   localparam logic [WORD_W-1:0] WORDS_LAST = WORD_W'(`DRV_WORDS_PER_FRAME - 1);
   localparam int BLANK_W = $clog2(`DRV_BLANK_CYCLES);
   localparam logic [BLANK_W-1:0] BLANK_LAST = BLANK_W'(`DRV_BLANK_CYCLES - 1);

   // Low while the FCWRTEN word goes out and high for the WRTFC word
   logic               cfg_phase;
   logic               frame_act;
   logic               blanking;
   logic [WORD_W-1:0]  word_cnt;
   logic [BLANK_W-1:0] blank_cnt;
   logic               sclk_en;
   logic               gclk_on;
   logic               frame_go;
   logic               word_end;

   // ######################################################################
   // Shift cycle decode
   // ######################################################################

   // A frame starts in the very cycle that sync is seen
   // The first slice is shifted right away so nothing has to be buffered
   assign frame_go = (state == STREAM) && stream_ready && framebuffer_sync;
   assign shift_en = (state == CONFIG) || frame_act || frame_go;

   // The FCWRTEN word is only 15 bits long and every other word is 48
   assign word_end = bit_idx == ((state == CONFIG && !cfg_phase) ? FC_LAST : WORD_LAST);

   always_comb begin
      lat_cmd = NO_LAT;
      sin_src = SIN_ZERO;
      if (state == CONFIG) begin
         lat_cmd = cfg_phase ? WRTFC : FCWRTEN;
         sin_src = cfg_phase ? SIN_CFG : SIN_ZERO;
      end else if (frame_act || frame_go) begin
         // Only the last word of a frame moves the GS data to the output bank
         lat_cmd = (word_cnt == WORDS_LAST) ? LATGS : WRTGS;
         sin_src = SIN_FB;
      end
   end

   // ######################################################################
   // Mode FSM with the bit, word and blanking counters
   // ######################################################################

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         state        <= STALL;
         bit_idx      <= '0;
         word_cnt     <= '0;
         blank_cnt    <= '0;
         cfg_phase    <= 1'b0;
         frame_act    <= 1'b0;
         blanking     <= 1'b0;
         stream_ready <= 1'b0;
         lod_start    <= 1'b0;
         gclk_on      <= 1'b0;
      end else begin
         lod_start <= 1'b0;
         case (state)
            STALL: begin
               if (start) begin
                  state     <= CONFIG;
                  cfg_phase <= 1'b0;
                  bit_idx   <= '0;
               end
            end
            CONFIG: begin
               // FCWRTEN and WRTFC run back to back with no gap
               if (word_end) begin
                  bit_idx   <= '0;
                  cfg_phase <= 1'b1;
                  if (cfg_phase) begin
                     state        <= STREAM;
                     stream_ready <= 1'b1;
                  end
               end else begin
                  bit_idx <= bit_idx + 1'b1;
               end
            end
            STREAM: begin
               if (frame_go) begin
                  // Bit 0 of word 0 is shifted in this cycle
                  stream_ready <= 1'b0;
                  frame_act    <= 1'b1;
                  bit_idx      <= bit_idx_t'(1);
               end else if (stream_ready && lod_req) begin
                  stream_ready <= 1'b0;
                  lod_start    <= 1'b1;
                  state        <= LOD;
               end else if (frame_act) begin
                  if (word_end) begin
                     bit_idx <= '0;
                     if (word_cnt == WORDS_LAST) begin
                        // LATGS has gone out so the drivers now hold valid GS data
                        frame_act <= 1'b0;
                        blanking  <= 1'b1;
                        blank_cnt <= '0;
                        word_cnt  <= '0;
                        gclk_on   <= 1'b1;
                     end else begin
                        word_cnt <= word_cnt + 1'b1;
                     end
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else if (blanking) begin
                  if (blank_cnt == BLANK_LAST) begin
                     blanking     <= 1'b0;
                     stream_ready <= 1'b1;
                  end else begin
                     blank_cnt <= blank_cnt + 1'b1;
                  end
               end
            end
            LOD: begin
               // The scanner's done pulse hands control back to streaming
               if (lod_done) begin
                  state        <= STREAM;
                  stream_ready <= 1'b1;
               end
            end
            default: state <= STALL;
         endcase
      end
   end

   // ######################################################################
   // Clock gating
   // ######################################################################

   // The SCLK enable trails shift_en by one clock, just like SIN and LAT
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         sclk_en <= 1'b0;
      end else begin
         sclk_en <= shift_en;
      end
   end

   // Both enables change while the inverted clock is low, so no runt pulses
   // SCLK rises mid-cycle when SIN and LAT have settled
   assign driver_sclk = ~clk_33 & sclk_en;
   assign driver_gclk = ~clk_33 & gclk_on;

   a_no_gclk_in_config: assert property (
      @(posedge clk_33) disable iff (!nrst)
      (state == CONFIG) |-> !gclk_on
   );

   a_bit_idx_range: assert property (
      @(posedge clk_33) disable iff (!nrst)
      bit_idx < bit_idx_t'(`DRV_WORD_BITS)
   );

endmodule

/* source/lat_command_gen.sv */
`include "drv_params.svh"

module lat_command_gen (
   input  logic              clk_33,
   input  logic              nrst,
   input  logic              shift_en,
   input  drv_pkg::bit_idx_t bit_idx,
   input  drv_pkg::lat_cmd_t lat_cmd,
   output logic              driver_lat
);
   import drv_pkg::*;

   bit_idx_t lat_len;
   bit_idx_t word_len;
   logic     lat_next;

   // ######################################################################
   // Command lookup
   // ######################################################################

   // The drivers decode a command from how many SCLK edges see LAT high
   // LAT therefore covers the tail end of the word
   always_comb begin
      case (lat_cmd)
         FCWRTEN: begin
            // FCWRTEN is a short word that holds LAT high for every bit
            lat_len  = bit_idx_t'(`DRV_FCWRTEN_LEN);
            word_len = bit_idx_t'(`DRV_FCWRTEN_LEN);
         end
         WRTFC: begin
            lat_len  = bit_idx_t'(`DRV_WRTFC_LEN);
            word_len = bit_idx_t'(`DRV_WORD_BITS);
         end
         WRTGS: begin
            lat_len  = bit_idx_t'(`DRV_WRTGS_LEN);
            word_len = bit_idx_t'(`DRV_WORD_BITS);
         end
         LATGS: begin
            lat_len  = bit_idx_t'(`DRV_LATGS_LEN);
            word_len = bit_idx_t'(`DRV_WORD_BITS);
         end
         default: begin
            lat_len  = '0;
            word_len = bit_idx_t'(`DRV_WORD_BITS);
         end
      endcase
      lat_next = shift_en && (lat_cmd != NO_LAT) && (bit_idx >= word_len - lat_len);
   end

   // Registered alongside SIN so both are stable at the SCLK edge
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         driver_lat <= 1'b0;
      end else begin
         driver_lat <= lat_next;
      end
   end

   // LAT may only be seen in the clock that follows a shift cycle
   a_lat_only_after_shift: assert property (
      @(posedge clk_33) disable iff (!nrst)
      driver_lat |-> $past(shift_en)
   );

endmodule

/* source/sin_serializer.sv */
`include "drv_params.svh"

module sin_serializer (
   input  logic               clk_33,
   input  logic               nrst,
   input  logic               start,
   input  drv_pkg::cfg_word_t config_word,
   input  drv_pkg::sin_word_t framebuffer_dat,
   input  logic               shift_en,
   input  drv_pkg::bit_idx_t  bit_idx,
   input  drv_pkg::sin_src_t  sin_src,
   output drv_pkg::sin_word_t drivers_sin
);
   import drv_pkg::*;

   localparam bit_idx_t MSB_IDX = bit_idx_t'(`DRV_WORD_BITS - 1);

   cfg_word_t cfg_q;
   bit_idx_t  cfg_sel;
   logic      cfg_bit;

   // ######################################################################
   // Configuration capture
   // ######################################################################

   // The level on config_word only has to be valid alongside start
   always_ff @(posedge clk_33) begin
      if (start) begin
         cfg_q <= config_word;
      end
   end

   // The drivers expect the function control word MSB first
   assign cfg_sel = MSB_IDX - bit_idx;
   assign cfg_bit = cfg_q[cfg_sel];

   // ######################################################################
   // SIN register
   // ######################################################################

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         drivers_sin <= '0;
      end else if (!shift_en) begin
         // Lines rest at zero between shift bursts
         drivers_sin <= '0;
      end else begin
         case (sin_src)
            // Every driver in the column gets the same configuration
            SIN_CFG: drivers_sin <= {`DRV_CHANNELS{cfg_bit}};
            // One framebuffer slice holds this bit for all 30 drivers
            SIN_FB: drivers_sin <= framebuffer_dat;
            default: drivers_sin <= '0;
         endcase
      end
   end

endmodule

/* source/lod_scanner.sv */
`include "drv_params.svh"

module lod_scanner (
   input  logic               clk_33,
   input  logic               nrst,
   input  logic               lod_start,
   input  logic               driver_sout,
   output drv_pkg::mux_sel_t  driver_sout_mux,
   output logic               lod_done,
   output drv_pkg::sin_word_t lod_flags
);
   import drv_pkg::*;

   localparam mux_sel_t MUX_LAST = mux_sel_t'(`DRV_CHANNELS - 1);
   localparam int DWELL_W = $clog2(`DRV_LOD_DWELL);
   localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(`DRV_LOD_DWELL - 1);

   logic               busy;
   logic               scan;
   logic [DWELL_W-1:0] dwell_cnt;
   logic               sample;

   // ######################################################################
   // Multiplexer stepping
   // ######################################################################

   // The start cycle already counts as the first dwell clock on position 0
   assign scan   = lod_start || busy;
   // SOUT is taken in the last clock of a stay so the mux has settled
   assign sample = scan && (dwell_cnt == DWELL_LAST);

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         busy            <= 1'b0;
         dwell_cnt       <= '0;
         driver_sout_mux <= '0;
         lod_done        <= 1'b0;
         lod_flags       <= '0;
      end else begin
         lod_done <= 1'b0;
         if (lod_start) begin
            busy <= 1'b1;
         end
         if (scan) begin
            dwell_cnt <= (dwell_cnt == DWELL_LAST) ? '0 : dwell_cnt + 1'b1;
         end
         if (sample) begin
            lod_flags[driver_sout_mux] <= driver_sout;
            if (driver_sout_mux == MUX_LAST) begin
               // Park on position 0 ready for the next scan
               busy            <= 1'b0;
               driver_sout_mux <= '0;
               lod_done        <= 1'b1;
            end else begin
               driver_sout_mux <= driver_sout_mux + 1'b1;
            end
         end
      end
   end

   a_mux_in_range: assert property (
      @(posedge clk_33) disable iff (!nrst)
      driver_sout_mux <= MUX_LAST
   );

endmodule

/* source/led_driver_top.sv */
module led_driver_top (
   input  logic               clk_33,
   input  logic               nrst,
   input  logic               start,
   input  drv_pkg::cfg_word_t config_word,
   input  drv_pkg::sin_word_t framebuffer_dat,
   input  logic               framebuffer_sync,
   input  logic               lod_req,
   input  logic               driver_sout,
   output logic               driver_sclk,
   output logic               driver_gclk,
   output logic               driver_lat,
   output drv_pkg::sin_word_t drivers_sin,
   output drv_pkg::mux_sel_t  driver_sout_mux,
   output logic               stream_ready,
   output logic               lod_done,
   output drv_pkg::sin_word_t lod_flags
);
   import drv_pkg::*;

   // Shift cycle control shared by the LAT and SIN paths
   logic     shift_en;
   bit_idx_t bit_idx;
   lat_cmd_t lat_cmd;
   sin_src_t sin_src;
   logic     lod_start;

   // The mode output has no use at the top level and stays open
   driver_main_controller u_ctrl (
      .clk_33           (clk_33),
      .nrst             (nrst),
      .start            (start),
      .framebuffer_sync (framebuffer_sync),
      .lod_req          (lod_req),
      .lod_done         (lod_done),
      .state            (),
      .shift_en         (shift_en),
      .bit_idx          (bit_idx),
      .lat_cmd          (lat_cmd),
      .sin_src          (sin_src),
      .lod_start        (lod_start),
      .stream_ready     (stream_ready),
      .driver_sclk      (driver_sclk),
      .driver_gclk      (driver_gclk)
   );

   lat_command_gen u_lat (
      .clk_33     (clk_33),
      .nrst       (nrst),
      .shift_en   (shift_en),
      .bit_idx    (bit_idx),
      .lat_cmd    (lat_cmd),
      .driver_lat (driver_lat)
   );

   sin_serializer u_sin (
      .clk_33          (clk_33),
      .nrst            (nrst),
      .start           (start),
      .config_word     (config_word),
      .framebuffer_dat (framebuffer_dat),
      .shift_en        (shift_en),
      .bit_idx         (bit_idx),
      .sin_src         (sin_src),
      .drivers_sin     (drivers_sin)
   );

   lod_scanner u_lod (
      .clk_33          (clk_33),
      .nrst            (nrst),
      .lod_start       (lod_start),
      .driver_sout     (driver_sout),
      .driver_sout_mux (driver_sout_mux),
      .lod_done        (lod_done),
      .lod_flags       (lod_flags)
   );

endmodule

/* bench/drv_checker.sv */
`include "drv_params.svh"

module drv_checker (
   input  logic               clk_33,
   input  logic               driver_sclk,
   input  logic               driver_gclk,
   input  logic               driver_lat,
   input  drv_pkg::sin_word_t drivers_sin,
   input  drv_pkg::mux_sel_t  driver_sout_mux,
   input  logic               stream_ready,
   input  logic               lod_done,
   input  drv_pkg::sin_word_t lod_flags,
   input  string              test_name,
   input  logic [1:0]         test_kind,
   input  drv_pkg::cfg_word_t test_cfg,
   input  drv_pkg::sin_word_t test_open,
   input  drv_pkg::sin_word_t slices [`DRV_WORD_BITS*`DRV_WORDS_PER_FRAME],
   input  logic               seg_begin,
   input  logic               seg_end,
   input  int                 exp_edges,
   output int                 error_total,
   output int                 tests_run,
   output int                 tests_failed
);
   timeunit 1ns;
   timeprecision 1ps;
   import drv_pkg::*;

   localparam logic [1:0] K_IDLE = 2'd0;
   localparam logic [1:0] K_CFG = 2'd1;
   localparam logic [1:0] K_FRAME = 2'd2;
   localparam logic [1:0] K_LOD = 2'd3;
   localparam int FRAME_EDGES = `DRV_WORD_BITS * `DRV_WORDS_PER_FRAME;
   localparam int FC_EDGES = `DRV_FCWRTEN_LEN;
   localparam int CFG_EDGES = `DRV_FCWRTEN_LEN + `DRV_WORD_BITS;

   int sclk_total = 0;
   int gclk_total = 0;
   int sclk_errs = 0;
   int mon_errs = 0;
   int seg_errs = 0;
   int edge_base = 0;
   int gclk_base = 0;
   int err_base = 0;
   int lod_steps = 0;
   mux_sel_t prev_mux = '0;

   assign error_total = sclk_errs + mon_errs + seg_errs;

   task automatic flag_mismatch(input string what, input logic [47:0] exp_v,
                                input logic [47:0] act_v, inout int cnt);
      $display("** Error %0s: %0s expected %0h actual %0h", test_name, what, exp_v, act_v);
      cnt++;
   endtask

   // ######################################################################
   // SIN and LAT at every SCLK rising edge
   // ######################################################################

   always @(posedge driver_sclk) begin
      int       idx;
      int       b;
      int       w;
      sin_word_t exp_sin;
      logic      exp_lat;
      idx = sclk_total - edge_base;
      sclk_total++;
      exp_sin = '0;
      exp_lat = 1'b0;
      if (test_kind == K_CFG && idx < CFG_EDGES) begin
         // FCWRTEN is all LAT and zero data, then the config word MSB first
         if (idx < FC_EDGES) begin
            exp_lat = 1'b1;
         end else begin
            b = idx - FC_EDGES;
            exp_sin = {`DRV_CHANNELS{test_cfg[`DRV_WORD_BITS-1-b]}};
            exp_lat = b >= (`DRV_WORD_BITS - `DRV_WRTFC_LEN);
         end
      end else if (test_kind == K_FRAME && idx < exp_edges) begin
         w = (idx % FRAME_EDGES) / `DRV_WORD_BITS;
         b = idx % `DRV_WORD_BITS;
         exp_sin = slices[idx % FRAME_EDGES];
         // The last word of a frame carries LATGS, the others WRTGS
         if (w == `DRV_WORDS_PER_FRAME - 1) begin
            exp_lat = b >= (`DRV_WORD_BITS - `DRV_LATGS_LEN);
         end else begin
            exp_lat = b >= (`DRV_WORD_BITS - `DRV_WRTGS_LEN);
         end
      end else begin
         $display("%0s: unexpected SCLK edge number %0d", test_name, idx);
         sclk_errs++;
      end
      if (drivers_sin !== exp_sin) begin
         flag_mismatch($sformatf("SIN at edge %0d", idx), 48'(exp_sin), 48'(drivers_sin),
                       sclk_errs);
      end
      if (driver_lat !== exp_lat) begin
         flag_mismatch($sformatf("LAT at edge %0d", idx), 48'(exp_lat), 48'(driver_lat),
                       sclk_errs);
      end
   end

   always @(posedge driver_gclk) begin
      gclk_total++;
   end

   // ######################################################################
   // Level checks between clock edges, where DUT outputs are stable
   // ######################################################################

   always @(negedge clk_33) begin
      if (test_kind == K_IDLE) begin
         if (driver_lat || (drivers_sin != '0) || stream_ready || lod_done) begin
            $display("%0s: outputs not idle after reset", test_name);
            mon_errs++;
         end
      end
      if (driver_sout_mux != prev_mux) begin
         if (driver_sout_mux == prev_mux + 1'b1) begin
            lod_steps++;
         end else if (!(driver_sout_mux == '0 && prev_mux == mux_sel_t'(`DRV_CHANNELS-1))) begin
            $display("%0s: SOUT mux jumped from %0d to %0d", test_name, prev_mux,
                     driver_sout_mux);
            mon_errs++;
         end
      end
      prev_mux = driver_sout_mux;
      if (lod_done) begin
         if (test_kind != K_LOD) begin
            $display("%0s: lod_done pulsed outside an LOD scan", test_name);
            mon_errs++;
         end
         if (lod_steps != `DRV_CHANNELS - 1) begin
            $display("%0s: SOUT mux made %0d steps instead of %0d", test_name, lod_steps,
                     `DRV_CHANNELS - 1);
            mon_errs++;
         end
         if (lod_flags !== test_open) begin
            flag_mismatch("lod_flags", 48'(test_open), 48'(lod_flags), mon_errs);
         end
         lod_steps = 0;
      end
   end

   // ######################################################################
   // Test boundaries and the per-test result line
   // ######################################################################

   always @(posedge clk_33) begin
      int edges;
      int gclks;
      int errs;
      if (seg_begin) begin
         edge_base = sclk_total;
         gclk_base = gclk_total;
         err_base = error_total;
      end
      if (seg_end) begin
         edges = sclk_total - edge_base;
         gclks = gclk_total - gclk_base;
         // A surplus edge here also means SCLK ran during blanking
         if (edges != exp_edges) begin
            $display("** Error %0s: SCLK edges expected %0d actual %0d", test_name, exp_edges,
                     edges);
            seg_errs++;
         end
         if ((test_kind == K_IDLE || test_kind == K_CFG) && gclks != 0) begin
            $display("%0s: GCLK toggled before any frame was latched", test_name);
            seg_errs++;
         end
         if ((test_kind == K_FRAME || test_kind == K_LOD) && gclks == 0) begin
            $display("%0s: GCLK is not running", test_name);
            seg_errs++;
         end
         errs = sclk_errs + mon_errs + seg_errs - err_base;
         tests_run++;
         if (errs != 0) begin
            tests_failed++;
            $display("FAIL %0s with %0d errors", test_name, errs);
         end else begin
            $display("PASS %0s", test_name);
         end
      end
   end

endmodule

/* bench/tb_led_driver.sv */
`include "drv_params.svh"

module tb_led_driver;
   timeunit 1ns;
   timeprecision 1ps;
   import drv_pkg::*;

   localparam logic [1:0] K_IDLE = 2'd0;
   localparam logic [1:0] K_CFG = 2'd1;
   localparam logic [1:0] K_FRAME = 2'd2;
   localparam logic [1:0] K_LOD = 2'd3;
   localparam int NROWS = 7;
   localparam int FRAME_EDGES = `DRV_WORD_BITS * `DRV_WORDS_PER_FRAME;
   localparam int IDLE_CYCLES = 20;

   logic clk_33;
   logic nrst;
   logic start;
   cfg_word_t config_word;
   sin_word_t framebuffer_dat;
   logic framebuffer_sync;
   logic lod_req;
   logic driver_sout;
   logic driver_sclk;
   logic driver_gclk;
   logic driver_lat;
   sin_word_t drivers_sin;
   mux_sel_t driver_sout_mux;
   logic stream_ready;
   logic lod_done;
   sin_word_t lod_flags;

   // Stimulus table, one row per test
   string      tbl_name [NROWS];
   logic [1:0] tbl_kind [NROWS];
   cfg_word_t  tbl_cfg [NROWS];
   int         tbl_frames [NROWS];
   sin_word_t  tbl_open [NROWS];

   // Expected values shared with the checker
   string      cur_name;
   logic [1:0] cur_kind;
   cfg_word_t  cur_cfg;
   sin_word_t  cur_open;
   sin_word_t  slices [FRAME_EDGES];
   logic       seg_begin;
   logic       seg_end;
   int         exp_edges;
   int         error_total;
   int         tests_run;
   int         tests_failed;
   logic [31:0] lfsr;
   int         cycles;
   int         cycle_limit;

   led_driver_top uut (.*);

   drv_checker u_chk (
      .clk_33 (clk_33), .driver_sclk (driver_sclk), .driver_gclk (driver_gclk),
      .driver_lat (driver_lat), .drivers_sin (drivers_sin),
      .driver_sout_mux (driver_sout_mux), .stream_ready (stream_ready),
      .lod_done (lod_done), .lod_flags (lod_flags), .test_name (cur_name),
      .test_kind (cur_kind), .test_cfg (cur_cfg), .test_open (cur_open),
      .slices (slices), .seg_begin (seg_begin), .seg_end (seg_end),
      .exp_edges (exp_edges), .error_total (error_total), .tests_run (tests_run),
      .tests_failed (tests_failed)
   );

   // The selected driver reports its open LED on SOUT
   assign driver_sout = cur_open[driver_sout_mux];

   always #20 clk_33 = ~clk_33;

   // ######################################################################
   // Random bits and stimulus helpers
   // ######################################################################

   // Fibonacci LFSR with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [47:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[46:0], lfsr[0]};
      end
   endtask

   task automatic wait_ready();
      while (!stream_ready) @(negedge clk_33);
   endtask

   task automatic end_segment();
      seg_end = 1'b1;
      @(negedge clk_33);
      seg_end = 1'b0;
   endtask

   // Streams one frame, one slice per clock starting with the sync cycle
   task automatic run_frame(input logic first);
      logic [47:0] v;
      // New slices are made only once the previous frame has been shifted out
      wait_ready();
      for (int k = 0; k < FRAME_EDGES; k++) begin
         take_bits(`DRV_CHANNELS, v);
         slices[k] = v[`DRV_CHANNELS-1:0];
      end
      seg_begin = first;
      framebuffer_sync = 1'b1;
      framebuffer_dat = slices[0];
      for (int k = 1; k < FRAME_EDGES; k++) begin
         @(negedge clk_33);
         seg_begin = 1'b0;
         framebuffer_sync = 1'b0;
         framebuffer_dat = slices[k];
      end
      @(negedge clk_33);
      framebuffer_dat = '0;
   endtask

   // SCLK edges that a row is expected to produce
   function automatic int row_edges(input int r);
      case (tbl_kind[r])
         K_CFG: row_edges = `DRV_FCWRTEN_LEN + `DRV_WORD_BITS;
         K_FRAME: row_edges = FRAME_EDGES * tbl_frames[r];
         default: row_edges = 0;
      endcase
   endfunction

   function automatic int row_cycles(input int r);
      case (tbl_kind[r])
         K_IDLE: row_cycles = IDLE_CYCLES + 2;
         K_CFG: row_cycles = `DRV_FCWRTEN_LEN + `DRV_WORD_BITS + 4;
         K_FRAME: row_cycles = tbl_frames[r] * (FRAME_EDGES + `DRV_BLANK_CYCLES + 4);
         default: row_cycles = `DRV_CHANNELS * `DRV_LOD_DWELL + 4;
      endcase
   endfunction

   always @(posedge clk_33) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout: the run went past %0d clock cycles", cycle_limit);
         $display("Checks failed");
         $finish;
      end
   end

   // ######################################################################
   // Test sequence
   // ######################################################################

   initial begin
      logic [47:0] v;
      tbl_name = '{"reset_idle", "config_load", "frame_single", "frames_three",
                   "lod_fixed", "lod_mixed", "frame_after_lod"};
      tbl_kind = '{K_IDLE, K_CFG, K_FRAME, K_FRAME, K_LOD, K_LOD, K_FRAME};
      tbl_cfg = '{48'h0, 48'ha5c3_0f1e_9b27, 48'h0, 48'h0, 48'h0, 48'h0, 48'h0};
      tbl_frames = '{0, 0, 1, 3, 0, 0, 1};
      // LOD rows mix the table pattern with LFSR bits
      tbl_open = '{30'h0, 30'h0, 30'h0, 30'h0, 30'h2000_0001, 30'h1555_5555, 30'h0};
      clk_33 = 1'b0;
      nrst = 1'b0;
      start = 1'b0;
      config_word = '0;
      framebuffer_dat = '0;
      framebuffer_sync = 1'b0;
      lod_req = 1'b0;
      seg_begin = 1'b0;
      seg_end = 1'b0;
      exp_edges = 0;
      cur_name = "reset";
      cur_kind = K_IDLE;
      cur_cfg = '0;
      cur_open = '0;
      lfsr = 32'hc92cf6f4;
      cycles = 0;
      cycle_limit = 10;
      for (int r = 0; r < NROWS; r++) cycle_limit += row_cycles(r);
      cycle_limit = cycle_limit * 11 / 10;
      for (int k = 0; k < FRAME_EDGES; k++) slices[k] = '0;
      repeat (10) @(posedge clk_33);
      @(negedge clk_33);
      nrst = 1'b1;
      for (int r = 0; r < NROWS; r++) begin
         cur_name = tbl_name[r];
         cur_kind = tbl_kind[r];
         cur_cfg = tbl_cfg[r];
         exp_edges = row_edges(r);
         case (tbl_kind[r])
            K_IDLE: begin
               seg_begin = 1'b1;
               @(negedge clk_33);
               seg_begin = 1'b0;
               repeat (IDLE_CYCLES) @(negedge clk_33);
               end_segment();
            end
            K_CFG: begin
               config_word = tbl_cfg[r];
               start = 1'b1;
               seg_begin = 1'b1;
               @(negedge clk_33);
               start = 1'b0;
               seg_begin = 1'b0;
               wait_ready();
               end_segment();
            end
            K_FRAME: begin
               for (int f = 0; f < tbl_frames[r]; f++) run_frame(f == 0);
               wait_ready();
               end_segment();
            end
            default: begin
               take_bits(`DRV_CHANNELS, v);
               cur_open = tbl_open[r] ^ v[`DRV_CHANNELS-1:0];
               wait_ready();
               lod_req = 1'b1;
               seg_begin = 1'b1;
               @(negedge clk_33);
               lod_req = 1'b0;
               seg_begin = 1'b0;
               while (!lod_done) @(negedge clk_33);
               wait_ready();
               end_segment();
            end
         endcase
      end
      repeat (2) @(negedge clk_33);
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total);
      if (tests_failed == 0 && error_total == 0 && tests_run == NROWS) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* Makefile */
# Verilator build and run for the LED driver column controller

VERILATOR ?= verilator
TOP       ?= tb_led_driver
RTL_TOP   ?= led_driver_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) +incdir+include \
		source/drv_pkg.sv source/driver_main_controller.sv source/lat_command_gen.sv \
		source/sin_serializer.sv source/lod_scanner.sv source/led_driver_top.sv

clean:
	rm -rf $(BUILD_DIR)

/* tb.f */
+incdir+include
source/drv_pkg.sv
source/driver_main_controller.sv
source/lat_command_gen.sv
source/sin_serializer.sv
source/lod_scanner.sv
source/led_driver_top.sv
bench/drv_checker.sv
bench/tb_led_driver.sv
